/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	typedef logic [31:0] xlen_t;     // Data, address and pc word
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  lane_t;     // One enable per bus byte

	//////////////////////////////
	// Encodings
	//////////////////////////////

	// Major opcodes from instr[6:2]
	typedef enum logic [4:0] {
		OPC_LOAD     = 5'b00000,
		OPC_STORE    = 5'b01000,
		OPC_OP_IMM   = 5'b00100,
		OPC_OP       = 5'b01100,
		OPC_LUI      = 5'b01101,
		OPC_AUIPC    = 5'b00101,
		OPC_JAL      = 5'b11011,
		OPC_JALR     = 5'b11001,
		OPC_BRANCH   = 5'b11000,
		OPC_MISC_MEM = 5'b00011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_DECODE,
		ST_EXECUTE,
		ST_MEM,
		ST_WRITEBACK
	} core_state_e;

	// Where the rd value comes from
	typedef enum logic [1:0] {
		RD_ALU,
		RD_LOAD,
		RD_LINK,
		RD_UPPER
	} rd_src_e;

	typedef struct packed {
		opcode_e    opcode;
		logic [2:0] funct3;
		alu_op_e    alu_op;
		reg_addr_t  rd;
		reg_addr_t  rs1;
		reg_addr_t  rs2;
		xlen_t      imm;       // Already picked for the format
		logic       use_imm;   // Immediate as second ALU operand
		logic       writes_rd; // Register write with rd not x0
	} dec_instr_t;

endpackage

`default_nettype wire

/* rtl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode
(
	input  wire rv_pkg::xlen_t instr,
	output rv_pkg::dec_instr_t dec
);

	rv_pkg::opcode_e opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	rv_pkg::xlen_t   imm_i;
	rv_pkg::xlen_t   imm_s;
	rv_pkg::xlen_t   imm_b;
	rv_pkg::xlen_t   imm_u;
	rv_pkg::xlen_t   imm_j;

	assign opcode = rv_pkg::opcode_e'(instr[6:2]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// Immediates for each format
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'd0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb
	begin
		dec.opcode = opcode;
		dec.funct3 = funct3;
		dec.rd     = instr[11:7];
		dec.rs1    = instr[19:15];
		dec.rs2    = instr[24:20];

		case (opcode)
			rv_pkg::OPC_STORE:                    dec.imm = imm_s;
			rv_pkg::OPC_BRANCH:                   dec.imm = imm_b;
			rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC:   dec.imm = imm_u;
			rv_pkg::OPC_JAL:                      dec.imm = imm_j;
			default:                              dec.imm = imm_i; // Loads, OP_IMM, JALR
		endcase

		// Only OP and OP_IMM look at funct3 for the ALU
		dec.alu_op = rv_pkg::ALU_ADD;
		if (opcode == rv_pkg::OPC_OP || opcode == rv_pkg::OPC_OP_IMM)
		begin
			case (funct3)
				3'b000:
				begin
					if (opcode == rv_pkg::OPC_OP && funct7[5])
						dec.alu_op = rv_pkg::ALU_SUB; // No SUBI
				end
				3'b001:  dec.alu_op = rv_pkg::ALU_SLL;
				3'b010:  dec.alu_op = rv_pkg::ALU_SLT;
				3'b011:  dec.alu_op = rv_pkg::ALU_SLTU;
				3'b100:  dec.alu_op = rv_pkg::ALU_XOR;
				3'b101:
				begin
					if (funct7[5])
						dec.alu_op = rv_pkg::ALU_SRA;
					else
						dec.alu_op = rv_pkg::ALU_SRL;
				end
				3'b110:  dec.alu_op = rv_pkg::ALU_OR;
				default: dec.alu_op = rv_pkg::ALU_AND;
			endcase
		end

		dec.use_imm = opcode != rv_pkg::OPC_OP;

		// Unknown opcodes and FENCE write nothing
		case (opcode)
			rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC,
			rv_pkg::OPC_JAL, rv_pkg::OPC_JALR, rv_pkg::OPC_LOAD:
				dec.writes_rd = instr[11:7] != 5'd0;
			default:
				dec.writes_rd = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
(
	input  wire                    clk,
	input  wire rv_pkg::reg_addr_t rs1,
	input  wire rv_pkg::reg_addr_t rs2,
	output rv_pkg::xlen_t          rs1_data,
	output rv_pkg::xlen_t          rs2_data,
	input  wire rv_pkg::reg_addr_t rd,
	input  wire rv_pkg::xlen_t     rd_value,
	input  wire                    rd_we
);

	rv_pkg::xlen_t regs [1:31]; // x0 has no storage

	assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

	always_ff @(posedge clk)
	begin
		if (rd_we && rd != 5'd0)
			regs[rd] <= rd_value;
	end

	// Decode already drops rd = x0 from writes_rd
	assert property (@(posedge clk) rd_we |-> rd != 5'd0)
	else $error("rv_regfile: write request to x0");

endmodule

`default_nettype wire

/* rtl/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute
(
	input  wire rv_pkg::dec_instr_t dec,
	input  wire rv_pkg::xlen_t      op_a,
	input  wire rv_pkg::xlen_t      op_b,
	input  wire rv_pkg::xlen_t      instr_pc,
	output rv_pkg::xlen_t           alu_result,
	output logic                    branch_taken,
	output rv_pkg::xlen_t           target,
	output rv_pkg::xlen_t           mem_addr,
	output rv_pkg::lane_t           store_lane,
	output rv_pkg::xlen_t           store_data
);

	rv_pkg::xlen_t alu_b;
	logic [4:0]    shamt;
	logic          cond;

	assign alu_b = dec.use_imm ? dec.imm : op_b;
	assign shamt = alu_b[4:0];

	//////////////////////////////
	// ALU
	//////////////////////////////

	always_comb
	begin
		case (dec.alu_op)
			rv_pkg::ALU_SUB:  alu_result = op_a - alu_b;
			rv_pkg::ALU_AND:  alu_result = op_a & alu_b;
			rv_pkg::ALU_OR:   alu_result = op_a | alu_b;
			rv_pkg::ALU_XOR:  alu_result = op_a ^ alu_b;
			rv_pkg::ALU_SLT:  alu_result = {31'd0, $signed(op_a) < $signed(alu_b)};
			rv_pkg::ALU_SLTU: alu_result = {31'd0, op_a < alu_b};
			rv_pkg::ALU_SLL:  alu_result = op_a << shamt;
			rv_pkg::ALU_SRL:  alu_result = op_a >> shamt;
			rv_pkg::ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
			default:          alu_result = op_a + alu_b;
		endcase
	end

	//////////////////////////////
	// Branches and jumps
	//////////////////////////////

	always_comb
	begin
		case (dec.funct3)
			3'b000:  cond = op_a == op_b;                   // BEQ
			3'b001:  cond = op_a != op_b;                   // BNE
			3'b100:  cond = $signed(op_a) < $signed(op_b);  // BLT
			3'b101:  cond = $signed(op_a) >= $signed(op_b); // BGE
			3'b110:  cond = op_a < op_b;                    // BLTU
			3'b111:  cond = op_a >= op_b;                   // BGEU
			default: cond = 1'b0;
		endcase
	end

	assign branch_taken = (dec.opcode == rv_pkg::OPC_BRANCH) && cond;

	// JALR is register relative with bit 0 cleared
	assign target = (dec.opcode == rv_pkg::OPC_JALR) ? ((op_a + dec.imm) & ~32'd1)
		: instr_pc + dec.imm;

	//////////////////////////////
	// Load and store
	//////////////////////////////

	assign mem_addr = op_a + dec.imm; // I or S immediate

	always_comb
	begin
		case (dec.funct3[1:0])
			2'b00:
			begin
				store_lane = 4'b0001 << mem_addr[1:0];
				store_data = {4{op_b[7:0]}};
			end
			2'b01:
			begin
				store_lane = mem_addr[1] ? 4'b1100 : 4'b0011;
				store_data = {2{op_b[15:0]}};
			end
			default:
			begin
				store_lane = 4'b1111;
				store_data = op_b;
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/rv_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_writeback
(
	input  wire rv_pkg::dec_instr_t dec,
	input  wire rv_pkg::xlen_t      alu_result,
	input  wire rv_pkg::xlen_t      load_word,
	input  wire [1:0]               addr_low,
	input  wire rv_pkg::xlen_t      link,
	output rv_pkg::xlen_t           rd_value
);

	rv_pkg::rd_src_e rd_src;
	rv_pkg::xlen_t   shifted;
	rv_pkg::xlen_t   load_value;
	rv_pkg::xlen_t   upper;

	// Addressed byte or half moved down to bit 0
	assign shifted = load_word >> {addr_low, 3'b000};

	always_comb
	begin
		case (dec.funct3)
			3'b000:  load_value = {{24{shifted[7]}}, shifted[7:0]};   // LB
			3'b001:  load_value = {{16{shifted[15]}}, shifted[15:0]}; // LH
			3'b100:  load_value = {24'd0, shifted[7:0]};              // LBU
			3'b101:  load_value = {16'd0, shifted[15:0]};             // LHU
			default: load_value = load_word;                          // LW
		endcase
	end

	// Link less four is the instruction pc
	assign upper = (dec.opcode == rv_pkg::OPC_LUI) ? dec.imm
		: link - 32'd4 + dec.imm;

	always_comb
	begin
		case (dec.opcode)
			rv_pkg::OPC_LOAD:                   rd_src = rv_pkg::RD_LOAD;
			rv_pkg::OPC_JAL, rv_pkg::OPC_JALR:  rd_src = rv_pkg::RD_LINK;
			rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: rd_src = rv_pkg::RD_UPPER;
			default:                            rd_src = rv_pkg::RD_ALU;
		endcase
	end

	always_comb
	begin
		case (rd_src)
			rv_pkg::RD_LOAD:  rd_value = load_value;
			rv_pkg::RD_LINK:  rd_value = link;
			rv_pkg::RD_UPPER: rd_value = upper;
			default:          rd_value = alu_result;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/rv_control.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_control
#(
	parameter rv_pkg::xlen_t reset_pc = 32'h0000_0000
)
(
	input  wire                     clk,
	input  wire                     rst,

	output rv_pkg::xlen_t           addr,
	output rv_pkg::xlen_t           dout,
	input  wire rv_pkg::xlen_t      din,
	output logic                    wr,
	output rv_pkg::lane_t           lane,
	output logic                    valid,
	input  wire                     ready,

	output rv_pkg::xlen_t           instr,
	input  wire rv_pkg::dec_instr_t dec,
	input  wire rv_pkg::xlen_t      rs1_data,
	input  wire rv_pkg::xlen_t      rs2_data,
	output rv_pkg::xlen_t           op_a,
	output rv_pkg::xlen_t           op_b,
	output rv_pkg::xlen_t           instr_pc,
	input  wire rv_pkg::xlen_t      alu_result,
	input  wire                     branch_taken,
	input  wire rv_pkg::xlen_t      target,
	input  wire rv_pkg::xlen_t      mem_addr,
	input  wire rv_pkg::lane_t      store_lane,
	input  wire rv_pkg::xlen_t      store_data,
	output rv_pkg::xlen_t           load_word,
	output logic                    rd_we
);

	rv_pkg::core_state_e state;
	rv_pkg::xlen_t       pc;
	rv_pkg::dec_instr_t  dec_q;
	logic                is_load;
	logic                is_store;
	logic                is_jump;
	logic                done;

	assign is_load  = dec_q.opcode == rv_pkg::OPC_LOAD;
	assign is_store = dec_q.opcode == rv_pkg::OPC_STORE;
	assign is_jump  = dec_q.opcode == rv_pkg::OPC_JAL || dec_q.opcode == rv_pkg::OPC_JALR;
	assign done     = valid && ready; // Transfer completes this cycle

	assign rd_we = (state == rv_pkg::ST_WRITEBACK) && dec_q.writes_rd;

	//////////////////////////////
	// Phase FSM
	//////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= rv_pkg::ST_FETCH;
			pc    <= reset_pc;
			valid <= 1'b0;
			wr    <= 1'b0;
		end
		else
		begin
			case (state)
				rv_pkg::ST_FETCH:
				begin
					if (!valid)
						valid <= 1'b1;
					else if (ready)
					begin
						valid <= 1'b0;
						state <= rv_pkg::ST_DECODE;
					end
				end
				rv_pkg::ST_DECODE:
					state <= rv_pkg::ST_EXECUTE;
				rv_pkg::ST_EXECUTE:
				begin
					pc <= (is_jump || branch_taken) ? target : pc + 32'd4;
					if (is_load || is_store)
						state <= rv_pkg::ST_MEM;
					else
						state <= rv_pkg::ST_WRITEBACK; // FENCE and unknown too
				end
				rv_pkg::ST_MEM:
				begin
					if (!valid)
					begin
						wr    <= is_store;
						valid <= 1'b1;
					end
					else if (ready)
					begin
						wr    <= 1'b0;
						valid <= 1'b0;
						state <= rv_pkg::ST_WRITEBACK;
					end
				end
				default:
					state <= rv_pkg::ST_FETCH;
			endcase
		end
	end

	// Bus payload and instruction latches
	always_ff @(posedge clk)
	begin
		if (!valid && state == rv_pkg::ST_FETCH)
		begin
			addr <= pc;
			lane <= 4'b1111;
		end
		if (!valid && state == rv_pkg::ST_MEM)
		begin
			addr <= {mem_addr[31:2], 2'b00};
			lane <= is_store ? store_lane : 4'b1111; // Loads read the whole word
			dout <= store_data;
		end
		if (done && state == rv_pkg::ST_FETCH)
		begin
			instr    <= din;
			instr_pc <= pc;
		end
		if (done && state == rv_pkg::ST_MEM && is_load)
			load_word <= din;
		if (state == rv_pkg::ST_DECODE)
		begin
			op_a  <= rs1_data;
			op_b  <= rs2_data;
			dec_q <= dec;
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	assert property (@(posedge clk) disable iff (rst)
		valid && !ready |=> valid)
	else $error("rv_control: valid dropped before ready");

	assert property (@(posedge clk) disable iff (rst)
		valid && !ready |=> {addr, wr, lane, dout} === $past({addr, wr, lane, dout}))
	else $error("rv_control: bus request changed while waiting");

	// Address adder result against decoded access size
	assert property (@(posedge clk) disable iff (rst)
		state == rv_pkg::ST_EXECUTE && (is_load || is_store) |->
			!(dec_q.funct3[1:0] == 2'b01 && mem_addr[0]) &&
			!(dec_q.funct3[1:0] == 2'b10 && mem_addr[1:0] != 2'b00))
	else $error("rv_control: misaligned access at %h", mem_addr);

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core
#(
	parameter rv_pkg::xlen_t reset_pc = 32'h0000_0000
)
(
	input  wire                clk,
	input  wire                rst,
	output rv_pkg::xlen_t      addr,
	output rv_pkg::xlen_t      dout,
	input  wire rv_pkg::xlen_t din,
	output logic               wr,
	output rv_pkg::lane_t      lane,
	output logic               valid,
	input  wire                ready
);

	rv_pkg::xlen_t      instr;
	rv_pkg::dec_instr_t dec;
	rv_pkg::xlen_t      rs1_data;
	rv_pkg::xlen_t      rs2_data;
	rv_pkg::xlen_t      op_a;
	rv_pkg::xlen_t      op_b;
	rv_pkg::xlen_t      instr_pc;
	rv_pkg::xlen_t      alu_result;
	logic               branch_taken;
	rv_pkg::xlen_t      target;
	rv_pkg::xlen_t      mem_addr;
	rv_pkg::lane_t      store_lane;
	rv_pkg::xlen_t      store_data;
	rv_pkg::xlen_t      load_word;
	logic               rd_we;
	rv_pkg::xlen_t      rd_value;
	rv_pkg::xlen_t      link;

	assign link = instr_pc + 32'd4; // Return address for JAL and JALR

	rv_control #(.reset_pc(reset_pc)) rv_control_i
	(
		.clk(clk), .rst(rst),
		.addr(addr), .dout(dout), .din(din), .wr(wr), .lane(lane),
		.valid(valid), .ready(ready),
		.instr(instr), .dec(dec), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.op_a(op_a), .op_b(op_b), .instr_pc(instr_pc), .alu_result(alu_result),
		.branch_taken(branch_taken), .target(target), .mem_addr(mem_addr),
		.store_lane(store_lane), .store_data(store_data),
		.load_word(load_word), .rd_we(rd_we)
	);

	rv_decode rv_decode_i (.instr(instr), .dec(dec));

	rv_regfile rv_regfile_i
	(
		.clk(clk), .rs1(dec.rs1), .rs2(dec.rs2),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.rd(dec.rd), .rd_value(rd_value), .rd_we(rd_we)
	);

	rv_execute rv_execute_i
	(
		.dec(dec), .op_a(op_a), .op_b(op_b), .instr_pc(instr_pc),
		.alu_result(alu_result), .branch_taken(branch_taken), .target(target),
		.mem_addr(mem_addr), .store_lane(store_lane), .store_data(store_data)
	);

	rv_writeback rv_writeback_i
	(
		.dec(dec), .alu_result(alu_result), .load_word(load_word),
		.addr_low(mem_addr[1:0]), .link(link), .rd_value(rd_value)
	);

endmodule

`default_nettype wire

/* tests/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////
// Instruction encoders
//////////////////////////////

// I type, also R type with funct7 and rs2 packed into imm
function automatic rv_pkg::xlen_t itype_word(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic rv_pkg::xlen_t store_word(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

function automatic rv_pkg::xlen_t branch_word(input logic [12:0] off, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
endfunction

function automatic rv_pkg::xlen_t jal_word(input logic [20:0] off, input logic [4:0] rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
endfunction

function automatic rv_pkg::xlen_t lane_mask(input rv_pkg::lane_t l);
	return {{8{l[3]}}, {8{l[2]}}, {8{l[1]}}, {8{l[0]}}};
endfunction

function automatic rv_pkg::xlen_t merge_lanes(input rv_pkg::xlen_t old, input rv_pkg::xlen_t data,
	input rv_pkg::lane_t l);
	return (old & ~lane_mask(l)) | (data & lane_mask(l));
endfunction

task automatic emit_word(inout int n, input rv_pkg::xlen_t w);
	mem[n]  = w;
	mmem[n] = w;
	n++;
endtask

//////////////////////////////
// Program generator
//////////////////////////////

task automatic gen_program();
	int          n;
	int          kind;
	int          skip;
	int          sz;
	int          land;
	logic [2:0]  f3;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [4:0]  rb;
	logic [11:0] imm;
	logic [19:0] upper;
	logic [7:0]  off;
	n    = 0;
	land = 0;
	emit_word(n, {20'h00002, 5'd31, 7'h37}); // x31 = data window base
	for (int r = 1; r < 31; r++)
		emit_word(n, itype_word(12'($urandom), 5'd0, 3'd0, 5'(r), 7'h13));
	while (n < BODY_END)
	begin
		kind  = $urandom % 8;
		f3    = 3'($urandom);
		rd    = 5'($urandom % 31); // Never x31
		rs1   = 5'($urandom);
		rs2   = 5'($urandom);
		rb    = 5'(1 + $urandom % 30);
		imm   = 12'($urandom);
		upper = 20'($urandom);
		sz    = $urandom % 3;
		off   = 8'($urandom) & (8'hff << sz);
		skip  = 1 + $urandom % 3;
		if (n + skip > BODY_END)
			skip = 1;
		if ((kind == 4 || kind == 5) && n + skip > land)
			land = n + skip; // Furthest jump target so far
		case (kind)
			0, 1: emit_word(n, itype_word({1'b0, (f3 == 0 || f3 == 5) && imm[0], 5'd0, rs2},
				rs1, f3, rd, 7'h33));
			2:
			begin
				if (f3 == 1 || f3 == 5)
					imm = {1'b0, f3 == 5 && imm[11], 5'd0, imm[4:0]}; // Shift amount form
				emit_word(n, itype_word(imm, rs1, f3, rd, 7'h13));
			end
			3: emit_word(n, {upper, rd, imm[0] ? 7'h37 : 7'h17});
			4: emit_word(n, branch_word(13'(skip * 4), rs2, rs1, (f3 == 2 || f3 == 3) ? f3 + 3'd2 : f3));
			5: emit_word(n, jal_word(21'(skip * 4), rd));
			6:
			begin
				// No earlier jump may land on the JALR and skip its AUIPC
				if (n + 2 <= BODY_END && land <= n)
				begin
					emit_word(n, {20'd0, rb, 7'h17});
					emit_word(n, itype_word(12'(8 + imm[0]), rb, 3'd0, rd, 7'h67)); // Odd imm too
				end
				else
					emit_word(n, itype_word(12'd0, 5'd0, 3'd0, 5'd0, 7'h13));
			end
			default:
			begin
				if (imm[11])
					emit_word(n, itype_word({4'd0, off}, 5'd31, {imm[10] && sz != 2, 2'(sz)}, rd, 7'h03));
				else
					emit_word(n, store_word({4'd0, off}, rs2, 5'd31, 3'(sz)));
			end
		endcase
	end
	// Register dump, then spin
	for (int r = 1; r < 32; r++)
		emit_word(n, store_word(12'(DUMP_OFF + 4 * r), 5'(r), 5'd31, 3'd2));
	emit_word(n, 32'h0000_006f);
endtask

//////////////////////////////
// Reference model
//////////////////////////////

function automatic rv_pkg::xlen_t alu_model(input logic [2:0] f3, input logic sub,
	input logic arith, input rv_pkg::xlen_t a, input rv_pkg::xlen_t b);
	rv_pkg::xlen_t r;
	case (f3)
		3'd0: r = sub ? a - b : a + b;
		3'd1: r = a << b[4:0];
		3'd2: r = {31'd0, $signed(a) < $signed(b)};
		3'd3: r = {31'd0, a < b};
		3'd4: r = a ^ b;
		3'd5:
		begin
			if (arith)
				r = $signed(a) >>> b[4:0];
			else
				r = a >> b[4:0];
		end
		3'd6: r = a | b;
		default: r = a & b;
	endcase
	return r;
endfunction

function automatic logic branch_cond(input logic [2:0] f3, input rv_pkg::xlen_t a,
	input rv_pkg::xlen_t b);
	case (f3)
		3'd0: return a == b;
		3'd1: return a != b;
		3'd4: return $signed(a) < $signed(b);
		3'd5: return $signed(a) >= $signed(b);
		3'd6: return a < b;
		3'd7: return a >= b;
		default: return 1'b0;
	endcase
endfunction

function automatic rv_pkg::xlen_t load_model(input logic [2:0] f3, input rv_pkg::xlen_t word,
	input logic [1:0] ofs);
	rv_pkg::xlen_t v;
	v = word >> (8 * ofs);
	case (f3)
		3'd0: v = {{24{v[7]}}, v[7:0]};
		3'd1: v = {{16{v[15]}}, v[15:0]};
		3'd4: v = {24'd0, v[7:0]};
		3'd5: v = {16'd0, v[15:0]};
		default: v = word;
	endcase
	return v;
endfunction

// Bytes outside the lanes are don't care
task automatic record_store(input rv_pkg::xlen_t a, input logic [2:0] f3,
	input rv_pkg::xlen_t val, input int src);
	store_t s;
	s.addr = {a[31:2], 2'b00};
	s.lane = (f3[1:0] == 2'd0 ? 4'b0001 : f3[1:0] == 2'd1 ? 4'b0011 : 4'b1111) << a[1:0];
	s.data = val << (8 * a[1:0]);
	if (src != T_ALU)
		s.test = 3'(src);
	else if (a >= DATA_BASE + DUMP_OFF)
		s.test = 3'(T_ALU);
	else
		s.test = 3'(T_STORE);
	store_q.push_back(s);
	mmem[a[13:2]] = merge_lanes(mmem[a[13:2]], s.data, s.lane);
endtask

task automatic run_model();
	rv_pkg::xlen_t x [32];
	int            src [32]; // Test that owns each register value
	rv_pkg::xlen_t pc;
	rv_pkg::xlen_t npc;
	rv_pkg::xlen_t w;
	rv_pkg::xlen_t v;
	rv_pkg::xlen_t a;
	rv_pkg::xlen_t imm_i;
	logic [4:0]    rd;
	logic [4:0]    rs1;
	logic [4:0]    rs2;
	logic [2:0]    f3;
	logic          wrote;
	int            tag;
	for (int i = 0; i < 32; i++)
	begin
		x[i]   = '0;
		src[i] = T_ALU;
	end
	pc = RESET_PC;
	while (model_steps < 4000)
	begin
		w = mmem[pc[13:2]];
		fetch_q.push_back(pc);
		model_steps++;
		if (w == 32'h0000_006f)
			break;
		rd    = w[11:7];
		rs1   = w[19:15];
		rs2   = w[24:20];
		f3    = w[14:12];
		imm_i = {{20{w[31]}}, w[31:20]};
		npc   = pc + 4;
		wrote = 1'b1;
		tag   = T_ALU;
		case (w[6:0])
			7'h37: v = {w[31:12], 12'd0};
			7'h17: v = pc + {w[31:12], 12'd0};
			7'h6f:
			begin
				v   = pc + 4;
				tag = T_JUMP;
				npc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			end
			7'h67:
			begin
				v   = pc + 4;
				tag = T_JUMP;
				npc = (x[rs1] + imm_i) & ~32'd1;
			end
			7'h63:
			begin
				wrote = 1'b0;
				if (branch_cond(f3, x[rs1], x[rs2]))
					npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			end
			7'h13: v = alu_model(f3, 1'b0, w[30], x[rs1], imm_i);
			7'h33: v = alu_model(f3, w[30], w[30], x[rs1], x[rs2]);
			7'h03:
			begin
				a   = x[rs1] + imm_i;
				v   = load_model(f3, mmem[a[13:2]], a[1:0]);
				tag = T_LOAD;
				model_loads++;
			end
			7'h23:
			begin
				wrote = 1'b0;
				record_store(x[rs1] + {{20{w[31]}}, w[31:25], w[11:7]}, f3, x[rs2], src[rs2]);
			end
			default: wrote = 1'b0; // FENCE and unknown opcodes
		endcase
		if (wrote && rd != 5'd0)
		begin
			x[rd]   = v;
			src[rd] = tag;
		end
		pc = npc;
	end
endtask

`endif

/* tests/tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core;

	localparam rv_pkg::xlen_t RESET_PC  = 32'h0000_0000;
	localparam rv_pkg::xlen_t DATA_BASE = 32'h0000_2000; // Loads and stores live above
	localparam int            DUMP_OFF  = 'h400;
	localparam int            BODY_END  = 231;            // First word of the dump code
	localparam int            MEM_WORDS = 4096;

	// Test index, also used as the owner tag of a store
	localparam int T_RESET = 0;
	localparam int T_ALU   = 1;
	localparam int T_JUMP  = 2;
	localparam int T_LOAD  = 3;
	localparam int T_STORE = 4;
	localparam int T_BUS   = 5;

	typedef struct packed {
		rv_pkg::xlen_t addr;
		logic          wr;
		rv_pkg::lane_t lane;
		rv_pkg::xlen_t data;
	} bus_req_t;

	typedef struct packed {
		rv_pkg::xlen_t addr;
		rv_pkg::lane_t lane;
		rv_pkg::xlen_t data;
		logic [2:0]    test;
	} store_t;

	logic               clk = 1'b0;
	logic               rst;
	logic               ready;
	rv_pkg::xlen_t      din;
	wire rv_pkg::xlen_t addr;
	wire rv_pkg::xlen_t dout;
	wire                wr;
	wire rv_pkg::lane_t lane;
	wire                valid;

	rv_pkg::xlen_t mem [MEM_WORDS];  // Bus memory
	rv_pkg::xlen_t mmem [MEM_WORDS]; // Model memory
	rv_pkg::xlen_t fetch_q [$];
	store_t        store_q [$];
	string         names [6] = '{"reset", "alu", "jumps", "loads", "stores", "bus"};
	int            errs [6];
	int            checks [6];
	int            model_steps;
	int            model_loads;
	int            fetches_seen;
	int            stores_seen;
	int            loads_seen;
	int            stalls;
	int            wait_left = -1;
	int            cycles;
	int            limit = 100000;
	bit            run_done;
	bit            first_done;
	bus_req_t      held;

	`include "tb_model.svh"

	rv_core #(.reset_pc(RESET_PC)) rv_core_i
	(
		.clk(clk), .rst(rst), .addr(addr), .dout(dout), .din(din),
		.wr(wr), .lane(lane), .valid(valid), .ready(ready)
	);

	always #20 clk = ~clk;

	task automatic compare_value(input int test, input rv_pkg::xlen_t expected,
		input rv_pkg::xlen_t actual);
		checks[test]++;
		assert (actual === expected)
		else
		begin
			$display("ERROR %s: expected %h, actual %h", names[test], expected, actual);
			errs[test]++;
		end
	endtask

	task automatic expect_true(input int test, input logic ok, input string what);
		checks[test]++;
		assert (ok === 1'b1)
		else
		begin
			$display("Failure in %s: %s", names[test], what);
			errs[test]++;
		end
	endtask

	task automatic complete_transfer(input bus_req_t r);
		store_t s;
		if (!first_done)
		begin
			compare_value(T_RESET, RESET_PC, r.addr);
			expect_true(T_RESET, !r.wr && r.lane == 4'hf, "first transfer is not a word read");
			first_done = 1'b1;
		end
		if (r.wr)
		begin
			expect_true(T_STORE, stores_seen < store_q.size(), "write the model does not predict");
			if (stores_seen < store_q.size())
			begin
				s = store_q[stores_seen];
				compare_value(s.test, s.addr, r.addr);
				compare_value(s.test, 32'(s.lane), 32'(r.lane));
				compare_value(s.test, s.data & lane_mask(s.lane), r.data & lane_mask(s.lane));
			end
			stores_seen++;
			mem[r.addr[13:2]] = merge_lanes(mem[r.addr[13:2]], r.data, r.lane);
		end
		else if (r.addr < DATA_BASE)
		begin
			if (fetches_seen < fetch_q.size())
			begin
				compare_value(T_JUMP, fetch_q[fetches_seen], r.addr);
				expect_true(T_JUMP, r.lane == 4'hf, "fetch without all byte lanes");
			end
			fetches_seen++;
			run_done = fetches_seen >= fetch_q.size(); // Last one is the spin jump
		end
		else
			loads_seen++;
	endtask

	//////////////////////////////
	// Memory with random ready delay
	//////////////////////////////

	always @(posedge clk)
	begin
		bus_req_t      now;
		logic          next_ready;
		rv_pkg::xlen_t next_din;
		now        = {addr, wr, lane, dout};
		next_ready = 1'b0;
		next_din   = din;
		if (rst)
			expect_true(T_RESET, valid === 1'b0, "valid is high during reset");
		else if (valid && ready)
		begin
			expect_true(T_BUS, now === held, "bus request changed before ready");
			complete_transfer(now);
			wait_left = -1;
		end
		else if (valid)
		begin
			if (wait_left < 0)
			begin
				held      = now;
				wait_left = $urandom % 4;
				stalls    = stalls + wait_left;
			end
			else
			begin
				expect_true(T_BUS, now === held, "bus request changed while waiting");
				wait_left--;
			end
			if (wait_left == 0)
			begin
				next_ready = 1'b1;
				next_din   = mem[addr[13:2]];
			end
		end
		#1;
		ready = next_ready;
		din   = next_din;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("Timeout after %0d cycles, %0d of %0d fetches done",
				cycles, fetches_seen, fetch_q.size());
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial
	begin
		int failed;
		int total;
		rst   = 1'b0;
		ready = 1'b0;
		din   = '0;
		void'($urandom(32'h87983350));
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			mem[i]  = (i * 32'h9E37_79B9) ^ 32'hA5C3_0F1E;
			mmem[i] = mem[i];
		end
		gen_program();
		run_model();
		limit = 40 * model_steps + 16;
		#2 rst = 1'b1;
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		wait (run_done);
		repeat (2) @(posedge clk);
		compare_value(T_STORE, store_q.size(), stores_seen);
		compare_value(T_LOAD, model_loads, loads_seen);
		expect_true(T_BUS, stalls > 0, "ready was never held low");
		failed = 0;
		total  = 0;
		for (int i = 0; i < 6; i++)
		begin
			$display("%-7s %s  checks %0d  errors %0d", names[i],
				errs[i] == 0 ? "ok" : "FAILED", checks[i], errs[i]);
			failed += (errs[i] != 0);
			total  += errs[i];
		end
		$display("Tests 6  passed %0d  failed %0d  errors %0d  model instructions %0d",
			6 - failed, failed, total, model_steps);
		if (total == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+tests
rtl/rv_pkg.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_writeback.sv
rtl/rv_control.sv
rtl/rv_core.sv
tests/tb_core.sv
